// File: logic/glb_config.svh
`ifndef GLB_CONFIG_SVH
`define GLB_CONFIG_SVH

// stream and bank word widths
`define GLB_CGRA_DATA_WIDTH 16
`define GLB_BANK_DATA_WIDTH 64

// byte addressing
`define GLB_ADDR_WIDTH 10
`define GLB_BANK_BYTE_OFFSET 3

// store header queue
`define GLB_QUEUE_DEPTH 4
`define GLB_MAX_NUM_WORDS_WIDTH 8

// done pulse latency
`define GLB_LATENCY_WIDTH 3
`define GLB_FIXED_LATENCY 2
`define GLB_MAX_EXTRA_LATENCY 8

`endif

// File: logic/glb_pkg.sv
package glb_pkg;

`include "glb_config.svh"

    localparam int NUM_LANES = `GLB_BANK_DATA_WIDTH / `GLB_CGRA_DATA_WIDTH;

    // bank word, seen whole by the bank or as stream lanes by the dma
    typedef union packed {
        logic [`GLB_BANK_DATA_WIDTH-1:0]                      word;
        logic [NUM_LANES-1:0][`GLB_CGRA_DATA_WIDTH-1:0]       lane;
    } bank_word_t;

    // one strobe bit per byte
    typedef logic [`GLB_BANK_DATA_WIDTH/8-1:0] bank_strb_t;

    typedef logic [`GLB_ADDR_WIDTH-1:0] glb_addr_t;
    typedef logic [`GLB_MAX_NUM_WORDS_WIDTH-1:0] num_words_t;
    typedef logic [$clog2(`GLB_QUEUE_DEPTH)-1:0] q_idx_t;

    typedef struct packed {
        logic       valid;
        glb_addr_t  start_addr;
        num_words_t num_words;
    } st_header_t;

    // dma mode codes, 01 and 10 are both manual
    typedef logic [1:0] dma_mode_t;

    localparam dma_mode_t MODE_OFF = 2'b00;
    localparam dma_mode_t MODE_AUTO = 2'b11;

endpackage

// File: logic/glb_wr_if.sv
`timescale 1ns/10ps

interface glb_wr_if;
    import glb_pkg::*;

    // one write per cycle with wr_en high, no acceptance
    logic       wr_en;
    glb_addr_t  wr_addr;
    bank_word_t wr_data;
    bank_strb_t wr_strb;

    modport dma (
        output wr_en,
        output wr_addr,
        output wr_data,
        output wr_strb
    );

    modport bank (
        input wr_en,
        input wr_addr,
        input wr_data,
        input wr_strb
    );

endinterface

// File: logic/glb_st_header_queue.sv
`timescale 1ns/10ps
`include "glb_config.svh"

module glb_st_header_queue (
    input  logic                clk,
    input  logic                reset,
    input  logic                clk_en,
    input  logic                hdr_wr,
    input  glb_pkg::q_idx_t     hdr_idx,
    input  glb_pkg::glb_addr_t  hdr_start_addr,
    input  glb_pkg::num_words_t hdr_num_words,
    input  logic                invalidate [`GLB_QUEUE_DEPTH],
    output glb_pkg::st_header_t headers [`GLB_QUEUE_DEPTH],
    output logic                hdr_valid [`GLB_QUEUE_DEPTH]
);
    import glb_pkg::*;

    logic       valid_r [`GLB_QUEUE_DEPTH];
    glb_addr_t  start_addr_r [`GLB_QUEUE_DEPTH];
    num_words_t num_words_r [`GLB_QUEUE_DEPTH];

    // valid bits, a write takes priority over invalidation
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `GLB_QUEUE_DEPTH; i++) begin
                valid_r[i] <= 1'b0;
            end
        end else if (clk_en) begin
            for (int i = 0; i < `GLB_QUEUE_DEPTH; i++) begin
                if (hdr_wr && hdr_idx == q_idx_t'(i)) begin
                    valid_r[i] <= 1'b1;
                end else if (invalidate[i]) begin
                    valid_r[i] <= 1'b0;
                end
            end
        end
    end

    // header fields
    always_ff @(posedge clk) begin
        if (clk_en) begin
            for (int i = 0; i < `GLB_QUEUE_DEPTH; i++) begin
                if (hdr_wr && hdr_idx == q_idx_t'(i)) begin
                    start_addr_r[i] <= hdr_start_addr;
                    num_words_r[i] <= hdr_num_words;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `GLB_QUEUE_DEPTH; i++) begin
            headers[i].valid = valid_r[i];
            headers[i].start_addr = start_addr_r[i];
            headers[i].num_words = num_words_r[i];
            hdr_valid[i] = valid_r[i];
        end
    end

endmodule

// File: logic/glb_store_dma.sv
`timescale 1ns/10ps
`include "glb_config.svh"

module glb_store_dma (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          clk_en,
    input  logic [`GLB_CGRA_DATA_WIDTH-1:0] stream_data,
    input  logic                          stream_valid,
    input  glb_pkg::dma_mode_t            cfg_mode,
    input  glb_pkg::st_header_t           headers [`GLB_QUEUE_DEPTH],
    output logic                          invalidate [`GLB_QUEUE_DEPTH],
    output logic                          done_strobe,
    glb_wr_if.dma                         wr
);
    import glb_pkg::*;

    typedef enum logic [2:0] {OFF, IDLE, READY, ACC1, ACC2, ACC3, ACC4, DONE} state_t;

    state_t     state, next_state;
    bank_word_t cache, next_cache;
    bank_strb_t cache_strb, next_cache_strb;
    glb_addr_t  cur_addr, next_cur_addr;
    glb_addr_t  addr_step;
    num_words_t num_cnt, next_num_cnt;
    logic       first_word, next_first_word;
    q_idx_t     q_sel_r, q_sel;
    st_header_t sel_hdr;
    logic       dma_on, auto_on;
    logic       hdr_load;
    logic [1:0] acc_lane;

    assign dma_on = (cfg_mode != MODE_OFF);
    assign auto_on = (cfg_mode == MODE_AUTO);

    // manual mode always serves entry 0
    assign q_sel = auto_on ? q_sel_r : '0;
    assign sel_hdr = headers[q_sel];
    assign hdr_load = dma_on && (state == IDLE) && sel_hdr.valid && (sel_hdr.num_words != '0);

    // first word keeps start_addr, later words move 2 bytes on
    assign addr_step = first_word ? cur_addr
                                  : cur_addr + glb_addr_t'(`GLB_CGRA_DATA_WIDTH / 8);

    // lane filled by each accepting state
    always_comb begin
        case (state)
            READY: acc_lane = 2'd0;
            ACC1: acc_lane = 2'd1;
            ACC2: acc_lane = 2'd2;
            default: acc_lane = 2'd3;
        endcase
    end

    always_comb begin
        next_state = state;
        next_cache = cache;
        next_cache_strb = cache_strb;
        next_cur_addr = cur_addr;
        next_num_cnt = num_cnt;
        next_first_word = first_word;
        case (state)
            OFF: begin
                if (dma_on) begin
                    next_state = IDLE;
                end
            end
            IDLE: begin
                next_cache = '0;
                next_cache_strb = '0;
                if (hdr_load) begin
                    next_cur_addr = sel_hdr.start_addr;
                    next_num_cnt = sel_hdr.num_words;
                    next_first_word = 1'b1;
                    // start in the lane picked by the start address
                    case (sel_hdr.start_addr[2:1])
                        2'b00: next_state = READY;
                        2'b01: next_state = ACC1;
                        2'b10: next_state = ACC2;
                        default: next_state = ACC3;
                    endcase
                end
            end
            READY, ACC1, ACC2, ACC3: begin
                if (num_cnt == '0) begin
                    next_state = DONE;
                end else if (stream_valid) begin
                    next_cache.lane[acc_lane] = stream_data;
                    next_cache_strb[{acc_lane, 1'b0} +: 2] = 2'b11;
                    next_num_cnt = num_cnt - 1'b1;
                    next_cur_addr = addr_step;
                    next_first_word = 1'b0;
                    next_state = state_t'(state + 3'd1);
                end
            end
            ACC4: begin
                // full word goes out this cycle when words remain
                if (num_cnt == '0) begin
                    next_state = DONE;
                end else if (stream_valid) begin
                    next_cache = '0;
                    next_cache.lane[0] = stream_data;
                    next_cache_strb = bank_strb_t'(2'b11);
                    next_num_cnt = num_cnt - 1'b1;
                    next_cur_addr = addr_step;
                    next_first_word = 1'b0;
                    next_state = ACC1;
                end else begin
                    next_cache = '0;
                    next_cache_strb = '0;
                    next_state = READY;
                end
            end
            DONE: begin
                next_cache = '0;
                next_cache_strb = '0;
                next_num_cnt = '0;
                next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= OFF;
            cache_strb <= '0;
            cur_addr <= '0;
            num_cnt <= '0;
            first_word <= 1'b0;
        end else if (clk_en) begin
            state <= dma_on ? next_state : OFF;
            cache_strb <= next_cache_strb;
            cur_addr <= next_cur_addr;
            num_cnt <= next_num_cnt;
            first_word <= next_first_word;
        end
    end

    always_ff @(posedge clk) begin
        if (clk_en) begin
            cache <= next_cache;
        end
    end

    // round-robin pointer, only moves in auto mode
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q_sel_r <= '0;
        end else if (clk_en) begin
            if (!auto_on) begin
                q_sel_r <= '0;
            end else if (hdr_load) begin
                q_sel_r <= q_sel_r + 1'b1;
            end
        end
    end

    // clears the served entry one edge after the load
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `GLB_QUEUE_DEPTH; i++) begin
                invalidate[i] <= 1'b0;
            end
        end else if (clk_en) begin
            for (int i = 0; i < `GLB_QUEUE_DEPTH; i++) begin
                invalidate[i] <= hdr_load && (q_sel == q_idx_t'(i));
            end
        end
    end

    // full word from ACC4, partial tail from DONE
    assign wr.wr_en = (state == DONE) || (state == ACC4 && num_cnt != '0);
    assign wr.wr_addr = {cur_addr[`GLB_ADDR_WIDTH-1:`GLB_BANK_BYTE_OFFSET],
                         {`GLB_BANK_BYTE_OFFSET{1'b0}}};
    assign wr.wr_data = cache;
    assign wr.wr_strb = cache_strb;

    // DONE lasts a single cycle
    assign done_strobe = (state == DONE);

endmodule

// File: logic/glb_done_delay.sv
`timescale 1ns/10ps
`include "glb_config.svh"

module glb_done_delay (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          clk_en,
    input  logic                          pulse_in,
    input  logic [`GLB_LATENCY_WIDTH-1:0] cfg_latency,
    output logic                          pulse_out
);
    localparam int DEPTH = `GLB_FIXED_LATENCY + `GLB_MAX_EXTRA_LATENCY;
    localparam int SEL_WIDTH = $clog2(DEPTH + 1);

    logic [DEPTH-1:0]     line;
    logic [DEPTH:0]       taps;
    logic [SEL_WIDTH-1:0] tap_sel;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            line <= '0;
        end else if (clk_en) begin
            line <= {line[DEPTH-2:0], pulse_in};
        end
    end

    // tap 0 is the undelayed input
    assign taps = {line, pulse_in};
    assign tap_sel = SEL_WIDTH'(cfg_latency) + SEL_WIDTH'(`GLB_FIXED_LATENCY);
    assign pulse_out = taps[tap_sel];

endmodule

// File: logic/glb_bank.sv
`timescale 1ns/10ps
`include "glb_config.svh"

module glb_bank (
    input  logic                clk,
    input  logic                reset,
    input  logic                clk_en,
    input  logic                rd_en,
    input  glb_pkg::glb_addr_t  rd_addr,
    glb_wr_if.bank              wr,
    output glb_pkg::bank_word_t rd_data
);
    import glb_pkg::*;

    localparam int IDX_WIDTH = `GLB_ADDR_WIDTH - `GLB_BANK_BYTE_OFFSET;
    localparam int NUM_WORDS = 1 << IDX_WIDTH;
    localparam int NUM_BYTES = `GLB_BANK_DATA_WIDTH / 8;

    bank_word_t mem [NUM_WORDS];

    logic [IDX_WIDTH-1:0] wr_idx;
    logic [IDX_WIDTH-1:0] rd_idx;

    // word index from the byte address
    assign wr_idx = wr.wr_addr[`GLB_ADDR_WIDTH-1:`GLB_BANK_BYTE_OFFSET];
    assign rd_idx = rd_addr[`GLB_ADDR_WIDTH-1:`GLB_BANK_BYTE_OFFSET];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_WORDS; i++) begin
                mem[i] <= '0;
            end
            rd_data <= '0;
        end else if (clk_en) begin
            if (wr.wr_en) begin
                for (int b = 0; b < NUM_BYTES; b++) begin
                    if (wr.wr_strb[b]) begin
                        mem[wr_idx].word[8*b +: 8] <= wr.wr_data.word[8*b +: 8];
                    end
                end
            end
            // old data on a same-cycle write to the read address
            if (rd_en) begin
                rd_data <= mem[rd_idx];
            end
        end
    end

endmodule

// File: logic/glb_store_top.sv
`timescale 1ns/10ps
`include "glb_config.svh"

module glb_store_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            clk_en,
    input  logic [`GLB_CGRA_DATA_WIDTH-1:0] stream_data,
    input  logic                            stream_valid,
    input  logic                            cfg_hdr_wr,
    input  glb_pkg::q_idx_t                 cfg_hdr_idx,
    input  glb_pkg::glb_addr_t              cfg_hdr_start_addr,
    input  glb_pkg::num_words_t             cfg_hdr_num_words,
    input  glb_pkg::dma_mode_t              cfg_mode,
    input  logic [`GLB_LATENCY_WIDTH-1:0]   cfg_latency,
    output logic                            hdr_valid [`GLB_QUEUE_DEPTH],
    input  logic                            rd_en,
    input  glb_pkg::glb_addr_t              rd_addr,
    output glb_pkg::bank_word_t             rd_data,
    output logic                            done_pulse
);
    import glb_pkg::*;

    st_header_t headers [`GLB_QUEUE_DEPTH];
    logic       invalidate [`GLB_QUEUE_DEPTH];
    logic       done_strobe;

    glb_wr_if wr_bus ();

    glb_st_header_queue header_queue_i (
        .clk            (clk),
        .reset          (reset),
        .clk_en         (clk_en),
        .hdr_wr         (cfg_hdr_wr),
        .hdr_idx        (cfg_hdr_idx),
        .hdr_start_addr (cfg_hdr_start_addr),
        .hdr_num_words  (cfg_hdr_num_words),
        .invalidate     (invalidate),
        .headers        (headers),
        .hdr_valid      (hdr_valid)
    );

    glb_store_dma store_dma_i (
        .clk          (clk),
        .reset        (reset),
        .clk_en       (clk_en),
        .stream_data  (stream_data),
        .stream_valid (stream_valid),
        .cfg_mode     (cfg_mode),
        .headers      (headers),
        .invalidate   (invalidate),
        .done_strobe  (done_strobe),
        .wr           (wr_bus.dma)
    );

    // interrupt after the programmed latency
    glb_done_delay done_delay_i (
        .clk         (clk),
        .reset       (reset),
        .clk_en      (clk_en),
        .pulse_in    (done_strobe),
        .cfg_latency (cfg_latency),
        .pulse_out   (done_pulse)
    );

    glb_bank bank_i (
        .clk     (clk),
        .reset   (reset),
        .clk_en  (clk_en),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .wr      (wr_bus.bank),
        .rd_data (rd_data)
    );

endmodule

// File: tests/glb_store_tb.sv
`timescale 1ns/10ps
`include "glb_config.svh"

module glb_store_tb;
    import glb_pkg::*;

    // a few hundred cycles of 4 ns in total, wide margin on top
    localparam int WATCHDOG_NS = 20000;

    logic                            clk;
    logic                            reset;
    logic                            clk_en;
    logic [`GLB_CGRA_DATA_WIDTH-1:0] stream_data;
    logic                            stream_valid;
    logic                            cfg_hdr_wr;
    q_idx_t                          cfg_hdr_idx;
    glb_addr_t                       cfg_hdr_start_addr;
    num_words_t                      cfg_hdr_num_words;
    dma_mode_t                       cfg_mode;
    logic [`GLB_LATENCY_WIDTH-1:0]   cfg_latency;
    logic                            hdr_valid [`GLB_QUEUE_DEPTH];
    logic                            rd_en;
    glb_addr_t                       rd_addr;
    bank_word_t                      rd_data;
    logic                            done_pulse;

    // byte image of the bank
    logic [7:0]  model_mem [1 << `GLB_ADDR_WIDTH];
    logic [31:0] rng_state;

    glb_store_top glb_store_top_i (
        .clk                (clk),
        .reset              (reset),
        .clk_en             (clk_en),
        .stream_data        (stream_data),
        .stream_valid       (stream_valid),
        .cfg_hdr_wr         (cfg_hdr_wr),
        .cfg_hdr_idx        (cfg_hdr_idx),
        .cfg_hdr_start_addr (cfg_hdr_start_addr),
        .cfg_hdr_num_words  (cfg_hdr_num_words),
        .cfg_mode           (cfg_mode),
        .cfg_latency        (cfg_latency),
        .hdr_valid          (hdr_valid),
        .rd_en              (rd_en),
        .rd_addr            (rd_addr),
        .rd_data            (rd_data),
        .done_pulse         (done_pulse)
    );

    always #2 clk = ~clk;

    initial begin
        #(WATCHDOG_NS);
        abort_run("watchdog timeout, the run did not finish in time");
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // little-endian bytes of the word holding addr
    function automatic bank_word_t model_word(input glb_addr_t addr);
        bank_word_t w;
        int base;
        base = int'(addr) & ~7;
        for (int b = 0; b < 8; b++) begin
            w.word[8*b +: 8] = model_mem[base + b];
        end
        return w;
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_word(input string name, input bank_word_t exp, input bank_word_t act);
        if (exp !== act) begin
            abort_run($sformatf("CHECK FAILED %s: expected %h, actual %h",
                                name, exp.word, act.word));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            abort_run($sformatf("CHECK FAILED %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic set_mode(input dma_mode_t m);
        @(negedge clk);
        cfg_mode = m;
        wait_cycles(2);
    endtask

    task automatic write_header(input q_idx_t idx, input glb_addr_t start, input num_words_t n);
        @(negedge clk);
        cfg_hdr_wr = 1'b1;
        cfg_hdr_idx = idx;
        cfg_hdr_start_addr = start;
        cfg_hdr_num_words = n;
        @(negedge clk);
        cfg_hdr_wr = 1'b0;
    endtask

    // one word per valid cycle, gaps carry junk data with valid low
    task automatic send_stream(input glb_addr_t start, input int n, input bit gaps,
                               input int stall_at, input bit record);
        glb_addr_t a;
        logic      forced_done;
        a = start;
        forced_done = 1'b0;
        for (int i = 0; i < n; i++) begin
            if (i == stall_at) begin
                @(negedge clk);
                clk_en = 1'b0;
                stream_valid = 1'b1;
                stream_data = 16'hdead;
                repeat (5) @(negedge clk);
                clk_en = 1'b1;
                stream_valid = 1'b0;
            end
            rng_state = xorshift32(rng_state);
            if (gaps && (rng_state[1:0] == 2'b00 || (a[2:1] == 2'b00 && i > 0 && !forced_done))) begin
                // first lane 0 word after a full word sees the empty cycle
                forced_done = forced_done | (a[2:1] == 2'b00 && i > 0);
                @(negedge clk);
                stream_valid = 1'b0;
                stream_data = rng_state[15:0];
            end
            rng_state = xorshift32(rng_state);
            @(negedge clk);
            stream_valid = 1'b1;
            stream_data = rng_state[31:16];
            if (record) begin
                model_mem[int'(a)] = rng_state[23:16];
                model_mem[int'(a) + 1] = rng_state[31:24];
            end
            a = a + glb_addr_t'(2);
        end
        @(negedge clk);
        stream_valid = 1'b0;
    endtask

    task automatic read_word(input glb_addr_t addr, output bank_word_t data);
        @(negedge clk);
        rd_en = 1'b1;
        rd_addr = addr;
        @(negedge clk);
        rd_en = 1'b0;
        data = rd_data;
    endtask

    // word before the region through the word after it
    task automatic compare_range(input string name, input glb_addr_t start, input int n);
        bank_word_t got;
        int first_w;
        int last_w;
        first_w = int'(start) / 8 - 1;
        last_w = (int'(start) + 2 * n + 7) / 8;
        for (int w = first_w; w <= last_w; w++) begin
            read_word(glb_addr_t'(w * 8), got);
            check_word(name, model_word(glb_addr_t'(w * 8)), got);
        end
    endtask

    // called at the negedge just after the edge that took the last word
    task automatic expect_done_at(input string name, input int lat);
        for (int k = 1; k <= lat + 5; k++) begin
            @(negedge clk);
            check_bit(name, k == lat + 3, done_pulse);
        end
    endtask

    task automatic aligned_manual_transfer();
        set_mode(2'b01);
        write_header(2'd0, 10'h040, 8'd8);
        send_stream(10'h040, 8, 1'b0, -1, 1'b1);
        wait_cycles(4);
        compare_range("aligned_manual", 10'h040, 8);
        check_bit("aligned_manual hdr_valid", 1'b0, hdr_valid[0]);
    endtask

    task automatic unaligned_partial_transfer();
        // background data first, so unstrobed bytes must keep it
        write_header(2'd0, 10'h0a0, 8'd8);
        send_stream(10'h0a0, 8, 1'b0, -1, 1'b1);
        wait_cycles(4);
        // lane 2 start, tail ends in lane 2 of the next word
        write_header(2'd0, 10'h0a4, 8'd5);
        send_stream(10'h0a4, 5, 1'b0, -1, 1'b1);
        wait_cycles(4);
        compare_range("unaligned_partial", 10'h0a4, 5);
    endtask

    task automatic stream_gap_transfer();
        write_header(2'd0, 10'h100, 8'd12);
        send_stream(10'h100, 12, 1'b1, -1, 1'b1);
        wait_cycles(4);
        compare_range("stream_gaps", 10'h100, 12);
    endtask

    task automatic auto_round_robin();
        glb_addr_t  starts [4];
        num_words_t counts [4];
        starts = '{10'h200, 10'h242, 10'h284, 10'h2c6};
        counts = '{8'd6, 8'd5, 8'd7, 8'd4};
        set_mode(2'b11);
        for (int e = 0; e < 4; e++) begin
            write_header(q_idx_t'(e), starts[e], counts[e]);
        end
        for (int e = 0; e < 4; e++) begin
            send_stream(starts[e], int'(counts[e]), 1'b0, -1, 1'b1);
            wait_cycles(4);
        end
        for (int e = 0; e < 4; e++) begin
            compare_range("auto_round_robin", starts[e], int'(counts[e]));
            check_bit("auto_round_robin hdr_valid", 1'b0, hdr_valid[e]);
        end
        write_header(2'd0, 10'h300, 8'd0);
        wait_cycles(6);
        check_bit("zero_length hdr_valid", 1'b1, hdr_valid[0]);
    endtask

    task automatic done_latency_and_stall();
        set_mode(2'b01);
        cfg_latency = 3'd0;
        write_header(2'd0, 10'h320, 8'd6);
        send_stream(10'h320, 6, 1'b0, 3, 1'b1);
        expect_done_at("done_latency_0", 0);
        wait_cycles(12);
        cfg_latency = 3'd5;
        write_header(2'd0, 10'h360, 8'd5);
        send_stream(10'h360, 5, 1'b0, -1, 1'b1);
        expect_done_at("done_latency_5", 5);
        compare_range("clk_en_stall", 10'h320, 6);
        compare_range("done_latency_5", 10'h360, 5);
    endtask

    task automatic mode_off_ignored();
        set_mode(2'b00);
        write_header(2'd0, 10'h380, 8'd4);
        send_stream(10'h380, 4, 1'b0, -1, 1'b0);
        for (int k = 0; k < 16; k++) begin
            @(negedge clk);
            check_bit("mode_off done_pulse", 1'b0, done_pulse);
        end
        compare_range("mode_off", 10'h380, 4);
        check_bit("mode_off hdr_valid", 1'b1, hdr_valid[0]);
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        clk_en = 1'b1;
        stream_data = '0;
        stream_valid = 1'b0;
        cfg_hdr_wr = 1'b0;
        cfg_hdr_idx = '0;
        cfg_hdr_start_addr = '0;
        cfg_hdr_num_words = '0;
        cfg_mode = 2'b00;
        cfg_latency = '0;
        rd_en = 1'b0;
        rd_addr = '0;
        rng_state = 32'h91f2_9f0b;
        for (int i = 0; i < (1 << `GLB_ADDR_WIDTH); i++) begin
            model_mem[i] = 8'h00;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        aligned_manual_transfer();
        unaligned_partial_transfer();
        stream_gap_transfer();
        auto_round_robin();
        done_latency_and_stall();
        mode_off_ignored();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+logic
logic/glb_pkg.sv
logic/glb_wr_if.sv
logic/glb_st_header_queue.sv
logic/glb_store_dma.sv
logic/glb_done_delay.sv
logic/glb_bank.sv
logic/glb_store_top.sv
tests/glb_store_tb.sv

// File: Makefile
# Verilator build and run of the store path testbench

VERILATOR       ?= verilator
TOP             ?= glb_store_tb
FILELIST        ?= verilog.f
BUILD_DIR       ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing

.PHONY: sim clean

# the run exits non-zero on $fatal, so make fails with it
sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
